// ==== compile.f ====
source/adc_vga_pkg.sv
source/sample_mapper.sv
source/vga_timing.sv
source/frame_store.sv
source/apb_regs.sv
source/adc_vga_top.sv
tests/adc_vga_assert.sv
tests/tb_adc_vga.sv

// ==== source/adc_vga_pkg.sv ====
// typedefs, sample/write/pixel structs, nibble layout and apb register offsets
package adc_vga_pkg;

  typedef logic [3:0]  color_t;
  typedef logic [9:0]  adc_word_t;
  typedef logic [15:0] fb_word_t;
  typedef logic [11:0] fb_addr_t;
  typedef logic [15:0] drop_cnt_t;
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // raster counter, wide enough for 800 x 525.
  typedef logic [10:0] pos_t;

  typedef struct packed {
    adc_word_t x;
    adc_word_t y;
    logic      red;
    logic      green;
    logic      blue;
  } adc_sample_t;

  typedef struct packed {
    fb_addr_t   addr;
    logic [1:0] lane;
    logic [3:0] pix;
  } fb_write_t;

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } rgb_pixel_t;

  // bit positions inside one pixel nibble.
  localparam int PIX_RED     = 3;
  localparam int PIX_GREEN   = 2;
  localparam int PIX_BLUE    = 1;
  localparam int PIX_WRITTEN = 0;

  localparam apb_addr_t REG_CTRL  = 4'h0;
  localparam apb_addr_t REG_DROPS = 4'h4;

  typedef enum logic {
    INIT,
    RUN
  } fs_state_t;

endpackage

// ==== source/adc_vga_top.sv ====
// adc_vga_top: sample mapper, vga timing, frame store and apb registers
`timescale 1ns/10ps

module adc_vga_top
  import adc_vga_pkg::*;
#(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 6,
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic        pixel_clk,
  input  logic        rst_n,
  input  adc_sample_t adc_sample,
  input  logic        adc_valid,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  apb_data_t   pwdata,
  output apb_data_t   prdata,
  output logic        pready,
  output rgb_pixel_t  vga_rgb,
  output logic        vga_de,
  output logic        vga_hsync,
  output logic        vga_vsync
);

  // line length must be a multiple of four for the group prefetch.
  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  fb_write_t wr_req;
  logic      wr_valid;
  logic      wr_ack;
  logic      drop_pulse;
  logic      capture_en;
  logic      display_en;
  pos_t      hpos;
  pos_t      vpos;
  logic      de;
  logic      hsync;
  logic      vsync;

  sample_mapper #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS)
  ) sample_mapper_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .adc_sample(adc_sample),
    .adc_valid (adc_valid),
    .capture_en(capture_en),
    .wr_ack    (wr_ack),
    .wr_req    (wr_req),
    .wr_valid  (wr_valid),
    .drop_pulse(drop_pulse)
  );

  vga_timing #(
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) vga_timing_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .hpos     (hpos),
    .vpos     (vpos),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  frame_store #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL)
  ) frame_store_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .hpos      (hpos),
    .vpos      (vpos),
    .de        (de),
    .hsync     (hsync),
    .vsync     (vsync),
    .wr_req    (wr_req),
    .wr_valid  (wr_valid),
    .display_en(display_en),
    .wr_ack    (wr_ack),
    .vga_rgb   (vga_rgb),
    .vga_de    (vga_de),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  apb_regs apb_regs_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .drop_pulse(drop_pulse),
    .prdata    (prdata),
    .pready    (pready),
    .capture_en(capture_en),
    .display_en(display_en)
  );

endmodule

// ==== source/apb_regs.sv ====
// apb_regs: apb slave with control bits and saturating drop counter
`timescale 1ns/10ps

module apb_regs
  import adc_vga_pkg::*;
(
  input  logic      pixel_clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  input  logic      drop_pulse,
  output apb_data_t prdata,
  output logic      pready,
  output logic      capture_en,
  output logic      display_en
);

  drop_cnt_t drops;
  logic      wr_access;
  logic      clr_drops;

  // no wait states, no error response.
  assign pready    = psel && penable;
  assign wr_access = psel && penable && pwrite;
  assign clr_drops = wr_access && (paddr == REG_DROPS);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      capture_en <= 1'b0;
      display_en <= 1'b0;
      drops      <= '0;
    end else begin
      if (wr_access && (paddr == REG_CTRL)) begin
        capture_en <= pwdata[0];
        display_en <= pwdata[1];
      end
      // clear beats a drop in the same cycle.
      if (clr_drops) begin
        drops <= '0;
      end else if (drop_pulse && (drops != '1)) begin
        drops <= drops + drop_cnt_t'(1);
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        REG_CTRL:  prdata[1:0] = {display_en, capture_en};
        REG_DROPS: prdata[$bits(drop_cnt_t)-1:0] = drops;
        default:   prdata = '0;
      endcase
    end
  end

endmodule

// ==== source/frame_store.sv ====
// frame_store: word frame memory, init sweep, read/write arbitration and pixel output
`timescale 1ns/10ps

module frame_store
  import adc_vga_pkg::*;
#(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 6,
  parameter int H_TOTAL   = 800,
  parameter int V_TOTAL   = 525
) (
  input  logic       pixel_clk,
  input  logic       rst_n,
  input  pos_t       hpos,
  input  pos_t       vpos,
  input  logic       de,
  input  logic       hsync,
  input  logic       vsync,
  input  fb_write_t  wr_req,
  input  logic       wr_valid,
  input  logic       display_en,
  output logic       wr_ack,
  output rgb_pixel_t vga_rgb,
  output logic       vga_de,
  output logic       vga_hsync,
  output logic       vga_vsync
);

  localparam int AW    = FB_X_BITS + FB_Y_BITS - 2;
  localparam int WORDS = 2 ** AW;
  localparam int FB_W  = 2 ** FB_X_BITS;
  localparam int FB_H  = 2 ** FB_Y_BITS;

  fs_state_t  state;
  fb_addr_t   init_addr;
  logic       init_busy;
  fb_word_t   mem [WORDS];
  pos_t       ahead_h;
  pos_t       ahead_v;
  logic       rd_due;
  logic       rd_grant;
  logic       wr_grant;
  fb_addr_t   rd_addr;
  fb_word_t   rd_word;
  fb_word_t   shift_word;
  logic [3:0] cur_nib;
  logic       in_grid;
  logic [3:0] nib_d1;
  logic       de_d1;
  logic       hsync_d1;
  logic       vsync_d1;
  rgb_pixel_t next_rgb;

  // clear one word per cycle, then run.
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state     <= INIT;
      init_addr <= '0;
    end else if (state == INIT) begin
      init_addr <= init_addr + fb_addr_t'(1);
      if (init_addr == fb_addr_t'(WORDS - 1)) begin
        state <= RUN;
      end
    end
  end

  assign init_busy = state == INIT;

  // the group four pixels ahead wraps into the next line near the end of a line.
  always_comb begin
    if (hpos >= pos_t'(H_TOTAL - 4)) begin
      ahead_h = hpos - pos_t'(H_TOTAL - 4);
      ahead_v = (vpos == pos_t'(V_TOTAL - 1)) ? '0 : vpos + pos_t'(1);
    end else begin
      ahead_h = hpos + pos_t'(4);
      ahead_v = vpos;
    end
  end

  assign rd_due   = (hpos[1:0] == 2'b00) && (ahead_h < pos_t'(FB_W)) &&
                    (ahead_v < pos_t'(FB_H));
  assign rd_addr  = fb_addr_t'({ahead_v[FB_Y_BITS-1:0], ahead_h[FB_X_BITS-1:2]});
  // scanout reads win over sample writes.
  assign rd_grant = !init_busy && rd_due;
  assign wr_grant = !init_busy && !rd_due && wr_valid;
  assign wr_ack   = wr_grant;

  always_ff @(posedge pixel_clk) begin
    if (init_busy) begin
      mem[init_addr[AW-1:0]] <= '0;
    end else if (wr_grant) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_req.lane == 2'(i)) begin
          mem[wr_req.addr[AW-1:0]][i*4 +: 4] <= wr_req.pix;
        end
      end
    end
    if (rd_grant) begin
      rd_word <= mem[rd_addr[AW-1:0]];
    end
  end

  // lane 0 is the leftmost pixel of a group.
  assign cur_nib = (hpos[1:0] == 2'b00) ? rd_word[3:0] : shift_word[3:0];
  assign in_grid = (hpos < pos_t'(FB_W)) && (vpos < pos_t'(FB_H));

  always_ff @(posedge pixel_clk) begin
    if (hpos[1:0] == 2'b00) begin
      shift_word <= rd_word >> 4;
    end else begin
      shift_word <= shift_word >> 4;
    end
    nib_d1 <= in_grid ? cur_nib : 4'h0;
  end

  always_comb begin
    next_rgb = '0;
    if (de_d1 && display_en && !init_busy && nib_d1[PIX_WRITTEN]) begin
      next_rgb.red   = {4{nib_d1[PIX_RED]}};
      next_rgb.green = {4{nib_d1[PIX_GREEN]}};
      next_rgb.blue  = {4{nib_d1[PIX_BLUE]}};
    end
  end

  // two stages, matching the pixel path.
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      de_d1     <= 1'b0;
      hsync_d1  <= 1'b1;
      vsync_d1  <= 1'b1;
      vga_de    <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_rgb   <= '0;
    end else begin
      de_d1     <= de;
      hsync_d1  <= hsync;
      vsync_d1  <= vsync;
      vga_de    <= de_d1;
      vga_hsync <= hsync_d1;
      vga_vsync <= vsync_d1;
      vga_rgb   <= next_rgb;
    end
  end

endmodule

// ==== source/sample_mapper.sv ====
// sample_mapper: adc sample scaling and four-entry write request fifo with drop reporting
`timescale 1ns/10ps

module sample_mapper
  import adc_vga_pkg::*;
#(
  parameter int FB_X_BITS = 8,
  parameter int FB_Y_BITS = 6
) (
  input  logic        pixel_clk,
  input  logic        rst_n,
  input  adc_sample_t adc_sample,
  input  logic        adc_valid,
  input  logic        capture_en,
  input  logic        wr_ack,
  output fb_write_t   wr_req,
  output logic        wr_valid,
  output logic        drop_pulse
);

  localparam int ADC_BITS = $bits(adc_word_t);

  logic [FB_X_BITS-1:0] fb_x;
  logic [FB_Y_BITS-1:0] fb_y;
  fb_write_t            new_req;
  fb_write_t            fifo_mem [4];
  logic [1:0]           wr_ptr;
  logic [1:0]           rd_ptr;
  logic [2:0]           fifo_count;
  logic                 accept;
  logic                 push;
  logic                 pop;

  // top bits of each deflection.
  assign fb_x = adc_sample.x[ADC_BITS-1 -: FB_X_BITS];
  assign fb_y = adc_sample.y[ADC_BITS-1 -: FB_Y_BITS];

  // four pixels per word, so the low two x bits pick the lane.
  always_comb begin
    new_req                  = '0;
    new_req.addr             = fb_addr_t'({fb_y, fb_x[FB_X_BITS-1:2]});
    new_req.lane             = fb_x[1:0];
    new_req.pix[PIX_RED]     = adc_sample.red;
    new_req.pix[PIX_GREEN]   = adc_sample.green;
    new_req.pix[PIX_BLUE]    = adc_sample.blue;
    new_req.pix[PIX_WRITTEN] = 1'b1;
  end

  assign accept = adc_valid && capture_en;
  assign pop    = wr_ack;
  // a full fifo still takes a sample when it pops in the same cycle.
  assign push   = accept && ((fifo_count != 3'd4) || pop);

  always_ff @(posedge pixel_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= new_req;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
      drop_pulse <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      case ({push, pop})
        2'b10:   fifo_count <= fifo_count + 3'd1;
        2'b01:   fifo_count <= fifo_count - 3'd1;
        default: fifo_count <= fifo_count;
      endcase
      drop_pulse <= accept && !push;
    end
  end

  assign wr_req   = fifo_mem[rd_ptr];
  assign wr_valid = fifo_count != 3'd0;

endmodule

// ==== source/vga_timing.sv ====
// vga_timing: free-running raster counters with sync and data enable decode
`timescale 1ns/10ps

module vga_timing
  import adc_vga_pkg::*;
#(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic pixel_clk,
  input  logic rst_n,
  output pos_t hpos,
  output pos_t vpos,
  output logic de,
  output logic hsync,
  output logic vsync
);

  localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  logic line_end;
  logic frame_end;

  assign line_end  = hpos == pos_t'(H_TOTAL - 1);
  assign frame_end = vpos == pos_t'(V_TOTAL - 1);

  // reset parks the counters on the last back porch pixel.
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      hpos <= pos_t'(H_TOTAL - 1);
      vpos <= pos_t'(V_TOTAL - 1);
    end else if (line_end) begin
      hpos <= '0;
      if (frame_end) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + pos_t'(1);
      end
    end else begin
      hpos <= hpos + pos_t'(1);
    end
  end

  assign de = (hpos < pos_t'(H_VISIBLE)) && (vpos < pos_t'(V_VISIBLE));

  // syncs are active low.
  assign hsync = !((hpos >= pos_t'(H_SYNC_START)) && (hpos < pos_t'(H_SYNC_END)));
  assign vsync = !((vpos >= pos_t'(V_SYNC_START)) && (vpos < pos_t'(V_SYNC_END)));

endmodule

// ==== tests/adc_vga_assert.sv ====
// adc_vga_assert: bound checks on output sync, write handshake, fifo depth and apb ready
`timescale 1ns/10ps

module adc_vga_assert (
  input logic       pixel_clk,
  input logic       rst_n,
  input logic       vga_de,
  input logic       vga_hsync,
  input logic       wr_ack,
  input logic       wr_valid,
  input logic [2:0] fifo_count,
  input logic       psel,
  input logic       penable,
  input logic       pready
);

  int fail_count = 0;

  // hsync stays idle across the visible pixels.
  no_hsync_in_de: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    vga_de |-> vga_hsync)
    else begin
      fail_count++;
      $error("hsync active while vga_de is high");
    end

  ack_needs_valid: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    wr_ack |-> wr_valid)
    else begin
      fail_count++;
      $error("wr_ack without a pending write request");
    end

  fifo_in_range: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    fifo_count <= 3'd4)
    else begin
      fail_count++;
      $error("write fifo count above four");
    end

  // ready only in an access phase that follows one setup cycle.
  ready_in_access: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    pready |-> penable && $past(psel && !penable))
    else begin
      fail_count++;
      $error("pready outside an access phase that follows a setup phase");
    end

endmodule

bind frame_store adc_vga_assert frame_store_chk (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .vga_de    (vga_de),
  .vga_hsync (vga_hsync),
  .wr_ack    (1'b0),
  .wr_valid  (1'b0),
  .fifo_count(3'd0),
  .psel      (1'b0),
  .penable   (1'b0),
  .pready    (1'b0)
);

bind sample_mapper adc_vga_assert sample_mapper_chk (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .vga_de    (1'b0),
  .vga_hsync (1'b1),
  .wr_ack    (wr_ack),
  .wr_valid  (wr_valid),
  .fifo_count(fifo_count),
  .psel      (1'b0),
  .penable   (1'b0),
  .pready    (1'b0)
);

bind apb_regs adc_vga_assert apb_regs_chk (
  .pixel_clk (pixel_clk),
  .rst_n     (rst_n),
  .vga_de    (1'b0),
  .vga_hsync (1'b1),
  .wr_ack    (1'b0),
  .wr_valid  (1'b0),
  .fifo_count(3'd0),
  .psel      (psel),
  .penable   (penable),
  .pready    (pready)
);

// ==== tests/tb_adc_vga.sv ====
// tb_adc_vga: clocked testbench with apb tasks, sample table, scanout monitor and checks
`timescale 1ns/10ps

module tb_adc_vga
  import adc_vga_pkg::*;
();

  localparam int FB_X_BITS    = 4;
  localparam int FB_Y_BITS    = 3;
  localparam int H_VISIBLE    = 16;
  localparam int V_VISIBLE    = 8;
  localparam int H_TOTAL      = H_VISIBLE + 4 + 4 + 4;
  localparam int V_TOTAL      = V_VISIBLE + 1 + 2 + 1;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int NUM_PIX      = H_VISIBLE * V_VISIBLE;
  localparam int NUM_ROWS     = 16;
  localparam int NUM_FIXED    = 11;
  localparam int BURST_LEN    = 40;
  // frame boundaries waited for over all tests.
  localparam int FRAME_WAITS  = 12;
  localparam int WATCHDOG_CYCLES = (FRAME_WAITS + 2) * FRAME_CYCLES + NUM_ROWS * 10 + 400;

  typedef struct packed {
    adc_word_t            adc_x;
    adc_word_t            adc_y;
    logic [FB_X_BITS-1:0] fb_x;
    logic [FB_Y_BITS-1:0] fb_y;
    logic [2:0]           color;
    rgb_pixel_t           exp_pix;
  } sample_row_t;

  logic        pixel_clk;
  logic        rst_n;
  adc_sample_t adc_sample;
  logic        adc_valid;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  rgb_pixel_t  vga_rgb;
  logic        vga_de;
  logic        vga_hsync;
  logic        vga_vsync;

  sample_row_t table_rows [NUM_ROWS];
  rgb_pixel_t  exp_image [NUM_PIX];
  rgb_pixel_t  image [NUM_PIX];
  int          mon_x;
  int          mon_y;
  int          de_count;
  int          frame_pixels;
  int          frames;
  bit          line_has_de;
  logic        vsync_q;
  int          pixel_errors;
  int          reg_errors;
  int          other_errors;

  adc_vga_top #(
    .FB_X_BITS(FB_X_BITS),
    .FB_Y_BITS(FB_Y_BITS),
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (4),
    .H_SYNC   (4),
    .H_BACK   (4),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (1),
    .V_SYNC   (2),
    .V_BACK   (1)
  ) DUT (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .adc_sample(adc_sample),
    .adc_valid (adc_valid),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .vga_rgb   (vga_rgb),
    .vga_de    (vga_de),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  initial pixel_clk = 1'b0;
  always #10 pixel_clk = ~pixel_clk;

  // rebuilds the raster from de, hsync and vsync.
  always @(negedge pixel_clk) begin
    if (!rst_n) begin
      mon_x       = 0;
      mon_y       = 0;
      de_count    = 0;
      frames      = 0;
      line_has_de = 1'b0;
      vsync_q     = 1'b1;
    end else begin
      if (vga_de) begin
        if (mon_x < H_VISIBLE && mon_y < V_VISIBLE) begin
          image[mon_y * H_VISIBLE + mon_x] = vga_rgb;
        end
        mon_x++;
        de_count++;
        line_has_de = 1'b1;
      end
      if (!vga_hsync) begin
        mon_x = 0;
        if (line_has_de) begin
          mon_y++;
        end
        line_has_de = 1'b0;
      end
      if (!vga_vsync && vsync_q) begin
        frames++;
        frame_pixels = de_count;
        de_count     = 0;
      end
      if (!vga_vsync) begin
        mon_y = 0;
      end
      vsync_q = vga_vsync;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pixel_clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // a set color bit drives its whole channel.
  function automatic rgb_pixel_t expand_color(input logic [2:0] color);
    rgb_pixel_t pix;
    pix.red   = {4{color[2]}};
    pix.green = {4{color[1]}};
    pix.blue  = {4{color[0]}};
    return pix;
  endfunction

  // coordinate in the top bits, random noise below.
  function automatic adc_word_t to_adc(input int coord, input int bits);
    int low;
    low = $bits(adc_word_t) - bits;
    return adc_word_t'((coord << low) | ($urandom % (1 << low)));
  endfunction

  task automatic add_row(input int idx, input int x, input int y, input logic [2:0] color);
    table_rows[idx].adc_x   = to_adc(x, FB_X_BITS);
    table_rows[idx].adc_y   = to_adc(y, FB_Y_BITS);
    table_rows[idx].fb_x    = FB_X_BITS'(x);
    table_rows[idx].fb_y    = FB_Y_BITS'(y);
    table_rows[idx].color   = color;
    table_rows[idx].exp_pix = expand_color(color);
  endtask

  task automatic build_table();
    add_row(0, 0, 0, 3'b111);
    add_row(1, 15, 7, 3'b100);
    add_row(2, 15, 0, 3'b010);
    add_row(3, 0, 7, 3'b001);
    add_row(4, 4, 2, 3'b110);
    add_row(5, 5, 2, 3'b101);
    add_row(6, 6, 2, 3'b011);
    add_row(7, 7, 2, 3'b111);
    add_row(8, 9, 5, 3'b010);
    add_row(9, 9, 5, 3'b100);
    add_row(10, 3, 4, 3'b000);
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      add_row(i, (i * 5) % H_VISIBLE, (i * 3) % V_VISIBLE, 3'($urandom % 8));
    end
  endtask

  task automatic drive_sample(input adc_word_t x, input adc_word_t y, input logic [2:0] color);
    @(negedge pixel_clk);
    adc_sample = '{x: x, y: y, red: color[2], green: color[1], blue: color[0]};
    adc_valid  = 1'b1;
    @(negedge pixel_clk);
    adc_valid = 1'b0;
    repeat (2) @(negedge pixel_clk);
  endtask

  // consecutive samples starting at the first visible line of the next frame.
  task automatic drive_burst();
    next_frame();
    while (!vga_de) @(posedge pixel_clk);
    for (int i = 0; i < BURST_LEN; i++) begin
      @(negedge pixel_clk);
      adc_sample = '{x: to_adc(i % H_VISIBLE, FB_X_BITS), y: to_adc(i % V_VISIBLE, FB_Y_BITS),
                     red: 1'b1, green: 1'b0, blue: 1'b1};
      adc_valid  = 1'b1;
    end
    @(negedge pixel_clk);
    adc_valid = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(negedge pixel_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge pixel_clk);
    penable = 1'b1;
    @(posedge pixel_clk);
    while (!pready) @(posedge pixel_clk);
    @(negedge pixel_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(negedge pixel_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pixel_clk);
    penable = 1'b1;
    @(posedge pixel_clk);
    while (!pready) @(posedge pixel_clk);
    data = prdata;
    @(negedge pixel_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic next_frame();
    int start;
    start = frames;
    while (frames == start) @(posedge pixel_clk);
  endtask

  // one boundary to align, then one whole frame.
  task automatic capture_frame();
    next_frame();
    next_frame();
  endtask

  task automatic check_pixel(input string name, input rgb_pixel_t got, input rgb_pixel_t exp);
    if (got !== exp) begin
      pixel_errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input apb_data_t got,
                           input apb_data_t lo, input apb_data_t hi);
    if ($isunknown(got) || got < lo || got > hi) begin
      reg_errors++;
      if (lo == hi) begin
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, lo);
      end else begin
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h to 0x%h", name, got, lo, hi);
      end
    end
  endtask

  task automatic check_image(input bit blank);
    rgb_pixel_t want;
    for (int i = 0; i < NUM_PIX; i++) begin
      want = blank ? rgb_pixel_t'(0) : exp_image[i];
      check_pixel($sformatf("vga_rgb(%0d,%0d)", i % H_VISIBLE, i / H_VISIBLE), image[i], want);
    end
    if (frame_pixels != NUM_PIX) begin
      other_errors++;
      $display("frame showed %0d visible pixels instead of %0d", frame_pixels, NUM_PIX);
    end
  endtask

  initial begin
    apb_data_t rdata;
    int        assert_errors;
    rst_n        = 1'b0;
    adc_sample   = '0;
    adc_valid    = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pixel_errors = 0;
    reg_errors   = 0;
    other_errors = 0;
    frame_pixels = 0;
    void'($urandom(23801));
    build_table();
    for (int i = 0; i < NUM_PIX; i++) begin
      exp_image[i] = '0;
    end
    repeat (10) @(negedge pixel_clk);
    rst_n = 1'b1;

    // blank after reset, no drops.
    capture_frame();
    check_image(1'b1);
    apb_read(REG_DROPS, rdata);
    check_reg("prdata(REG_DROPS)", rdata, 0, 0);

    apb_write(REG_CTRL, 32'h3);
    apb_read(REG_CTRL, rdata);
    check_reg("prdata(REG_CTRL)", rdata, 32'h3, 32'h3);
    for (int i = 0; i < NUM_ROWS; i++) begin
      drive_sample(table_rows[i].adc_x, table_rows[i].adc_y, table_rows[i].color);
      exp_image[table_rows[i].fb_y * H_VISIBLE + table_rows[i].fb_x] = table_rows[i].exp_pix;
    end
    capture_frame();
    check_image(1'b0);

    // capture off, so the image must not move.
    apb_write(REG_CTRL, 32'h2);
    drive_burst();
    capture_frame();
    check_image(1'b0);
    apb_read(REG_DROPS, rdata);
    check_reg("prdata(REG_DROPS)", rdata, 0, 0);

    apb_write(REG_CTRL, 32'h0);
    capture_frame();
    check_image(1'b1);
    apb_write(REG_CTRL, 32'h2);
    capture_frame();
    check_image(1'b0);

    apb_write(REG_CTRL, 32'h3);
    drive_burst();
    apb_read(REG_DROPS, rdata);
    check_reg("prdata(REG_DROPS)", rdata, 1, BURST_LEN);
    apb_write(REG_DROPS, 32'h0);
    apb_read(REG_DROPS, rdata);
    check_reg("prdata(REG_DROPS)", rdata, 0, 0);

    assert_errors = DUT.frame_store_i.frame_store_chk.fail_count +
                    DUT.sample_mapper_i.sample_mapper_chk.fail_count +
                    DUT.apb_regs_i.apb_regs_chk.fail_count;
    $display("error count: pixel %0d, register %0d, other %0d, assertion %0d",
             pixel_errors, reg_errors, other_errors, assert_errors);
    if (pixel_errors + reg_errors + other_errors + assert_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
